// File: sources.f
rtl/osd_pkg.sv
rtl/spi_byte_rx.sv
rtl/cmd_decoder.sv
rtl/config_regs.sv
rtl/mem_word_fifo.sv
rtl/wb_write_master.sv
rtl/osd_ctrl_top.sv
bench/osd_ctrl_sva.sv
bench/osd_ctrl_tb.sv

// File: Bender.yml
package:
  name: osd_ctrl

sources:
  # design, package first
  - rtl/osd_pkg.sv
  - rtl/spi_byte_rx.sv
  - rtl/cmd_decoder.sv
  - rtl/config_regs.sv
  - rtl/mem_word_fifo.sv
  - rtl/wb_write_master.sv
  - rtl/osd_ctrl_top.sv
  # testbench
  - target: test
    files:
      - bench/osd_ctrl_sva.sv
      - bench/osd_ctrl_tb.sv

// File: bench/osd_ctrl_tb.sv
// osd command port testbench
module osd_ctrl_tb;

  localparam int fifo_depth = 4;
  localparam int n_words    = 6;
  localparam int sck_half   = 4;
  // every spi byte of every test, 64 clk per byte
  localparam int spi_bytes  = 9 * 3 + 2 + 7 + 4 + (5 + 2 * n_words) + (5 + 2 * fifo_depth);
  localparam int watchdog_cycles = spi_bytes * 8 * 8 + 3000;

  logic clk = 1'b0;
  logic reset;
  logic spi_cs_n;
  logic spi_sck;
  logic spi_sdi;
  logic spi_sdo;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [1:0] wb_sel;
  logic [osd_pkg::addr_w-1:0] wb_adr;
  logic [osd_pkg::data_w-1:0] wb_dat_w;
  logic wb_ack = 1'b0;
  osd_pkg::sys_config_t sys_config;
  logic fifo_full;

  // spi byte queues and bus write record
  logic [7:0] xfer_tx [$];
  logic [7:0] xfer_rx [$];
  osd_pkg::mem_word_t bus_q [$];
  osd_pkg::mem_word_t exp_q [$];
  osd_pkg::mem_word_t seen_word;
  osd_pkg::sys_config_t exp_cfg;

  // slave model state
  logic ack_hold = 1'b0;
  logic stall_armed;
  logic [1:0] stall_left;
  logic [31:0] stall_rng = 32'd83521;
  logic [31:0] rng = 32'd83521;

  int cfg_errs = 0;
  int word_errs = 0;
  int byte_errs = 0;
  int flag_errs = 0;
  int other_errs = 0;

  osd_pkg::opcode_e reg_ops [9] = '{osd_pkg::op_reset_ctrl, osd_pkg::op_osd_ctrl,
    osd_pkg::op_chip_cfg, osd_pkg::op_cpu_cfg, osd_pkg::op_mem_cfg, osd_pkg::op_video_cfg,
    osd_pkg::op_floppy_cfg, osd_pkg::op_hdd_cfg, osd_pkg::op_joy_cfg};

  osd_ctrl_top #(
    .fifo_depth (fifo_depth)
  ) i_dut (
    .clk        (clk),
    .reset      (reset),
    .spi_cs_n   (spi_cs_n),
    .spi_sck    (spi_sck),
    .spi_sdi    (spi_sdi),
    .spi_sdo    (spi_sdo),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_sel     (wb_sel),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_ack     (wb_ack),
    .sys_config (sys_config),
    .fifo_full  (fifo_full)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // ----------------------------------------
  // wishbone slave model
  // ----------------------------------------
  // random stall of 0 to 3 cycles, hold blocks the ack
  always @(posedge clk) begin
    if (reset) begin
      wb_ack      <= 1'b0;
      stall_armed <= 1'b0;
      stall_left  <= '0;
    end else begin
      if (wb_stb && wb_ack) begin
        seen_word.adr = wb_adr;
        seen_word.dat = wb_dat_w;
        bus_q.push_back(seen_word);
        // write enable and full lanes on every accepted write
        check_flag("wb_we", wb_we, 1'b1);
        check_sel(wb_sel, 2'b11);
      end
      if (wb_ack) begin
        wb_ack <= 1'b0;
      end else if (wb_stb) begin
        if (!stall_armed) begin
          stall_rng = xorshift32(stall_rng);
          stall_left  <= stall_rng[1:0];
          stall_armed <= 1'b1;
        end else if (stall_left != 2'd0) begin
          stall_left <= stall_left - 2'd1;
        end else if (!ack_hold) begin
          wb_ack      <= 1'b1;
          stall_armed <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_config(input osd_pkg::sys_config_t exp);
    if (sys_config !== exp) begin
      cfg_errs++;
      $display("Fail sys_config: got %h expected %h", sys_config, exp);
    end
  endtask

  task automatic check_word(input int k, input osd_pkg::mem_word_t got,
                            input osd_pkg::mem_word_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("Fail wb_adr/wb_dat_w write %0d: got %h/%h expected %h/%h",
               k, got.adr, got.dat, exp.adr, exp.dat);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      byte_errs++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_sel(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      flag_errs++;
      $display("Fail wb_sel: got %h expected %h", got, exp);
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic osd_pkg::sys_config_t reset_config();
    osd_pkg::sys_config_t c;
    c = '0;
    c.cpu_halt  = 1'b1;
    c.cpu_reset = 1'b1;
    c.memory    = 7'b0000101;
    return c;
  endfunction

  // field layouts per register opcode
  task automatic apply_reg_write(input osd_pkg::opcode_e op, input logic [7:0] d);
    case (op)
      osd_pkg::op_reset_ctrl: {exp_cfg.cpu_halt, exp_cfg.cpu_reset, exp_cfg.user_reset} = d[2:0];
      osd_pkg::op_osd_ctrl:   {exp_cfg.key_disable, exp_cfg.osd_enable} = d[1:0];
      osd_pkg::op_chip_cfg:   exp_cfg.chipset = d[4:0];
      osd_pkg::op_cpu_cfg:    exp_cfg.cpu = d[3:0];
      osd_pkg::op_mem_cfg:    exp_cfg.memory = d[6:0];
      osd_pkg::op_video_cfg:  {exp_cfg.dither, exp_cfg.hires_filter,
                               exp_cfg.lores_filter, exp_cfg.scanline} = d;
      osd_pkg::op_floppy_cfg: exp_cfg.floppy = d[3:0];
      osd_pkg::op_hdd_cfg:    exp_cfg.ide = d[2:0];
      osd_pkg::op_joy_cfg:    {exp_cfg.cd32pad, exp_cfg.autofire} = d[2:0];
      default: begin
      end
    endcase
  endtask

  // ----------------------------------------
  // spi master
  // ----------------------------------------
  // mode 0, sdo captured just before each rising sck
  task automatic spi_xfer();
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    xfer_rx.delete();
    @(posedge clk);
    spi_cs_n <= 1'b0;
    foreach (xfer_tx[i]) begin
      tx_byte = xfer_tx[i];
      for (int b = 7; b >= 0; b--) begin
        spi_sdi <= tx_byte[b];
        spi_sck <= 1'b0;
        repeat (sck_half - 1) @(posedge clk);
        @(negedge clk);
        rx_byte[b] = spi_sdo;
        @(posedge clk);
        spi_sck <= 1'b1;
        repeat (sck_half) @(posedge clk);
      end
      xfer_rx.push_back(rx_byte);
    end
    spi_sck <= 1'b0;
    repeat (sck_half) @(posedge clk);
    spi_cs_n <= 1'b1;
    spi_sdi  <= 1'b0;
    // register and version effects settle within 8 clk
    repeat (8) @(posedge clk);
  endtask

  task automatic load_cmd(input logic [5:0] op);
    xfer_tx.delete();
    xfer_tx.push_back({op, 2'b00});
  endtask

  // address bytes lsb first, then hi/lo pairs
  task automatic build_mem_write(input logic [31:0] start, input int n);
    logic [31:0] w;
    osd_pkg::mem_word_t e;
    load_cmd(osd_pkg::op_mem_write);
    for (int b = 0; b < 4; b++) xfer_tx.push_back(start[8*b +: 8]);
    for (int k = 0; k < n; k++) begin
      w = next_rand();
      xfer_tx.push_back(w[15:8]);
      xfer_tx.push_back(w[7:0]);
      e.adr = start[23:0] + 24'(2 * k);
      e.dat = w[15:0];
      exp_q.push_back(e);
    end
  endtask

  task automatic wait_bus_writes(input int n);
    int waited;
    waited = 0;
    while (bus_q.size() < n && waited < 500) begin
      @(posedge clk);
      waited++;
    end
    if (bus_q.size() < n) begin
      other_errs++;
      $display("timed out waiting for %0d bus writes, saw %0d", n, bus_q.size());
    end
  endtask

  task automatic compare_bus_writes();
    int k;
    k = 0;
    while (exp_q.size() != 0) begin
      if (bus_q.size() == 0) begin
        other_errs++;
        $display("bus write %0d never arrived", k);
        void'(exp_q.pop_front());
      end else begin
        check_word(k, bus_q.pop_front(), exp_q.pop_front());
      end
      k++;
    end
    repeat (20) @(posedge clk);
    if (bus_q.size() != 0) begin
      other_errs++;
      $display("%0d unexpected extra bus writes", bus_q.size());
      bus_q.delete();
    end
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic after_reset_state();
    exp_cfg = reset_config();
    check_config(exp_cfg);
    check_flag("fifo_full", fifo_full, 1'b0);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("wb_stb", wb_stb, 1'b0);
    check_flag("spi_sdo", spi_sdo, 1'b0);
  endtask

  // second data byte and unknown opcode are ignored
  task automatic register_writes();
    logic [31:0] r;
    for (int i = 0; i < 9; i++) begin
      r = next_rand();
      load_cmd(reg_ops[i]);
      xfer_tx.push_back(r[7:0]);
      xfer_tx.push_back(r[15:8]);
      spi_xfer();
      apply_reg_write(reg_ops[i], r[7:0]);
      check_config(exp_cfg);
    end
    r = next_rand();
    load_cmd(6'b111111);
    xfer_tx.push_back(r[7:0]);
    spi_xfer();
    check_config(exp_cfg);
  endtask

  task automatic version_readback();
    int idx;
    load_cmd(osd_pkg::op_version);
    repeat (6) xfer_tx.push_back(8'h00);
    spi_xfer();
    for (int k = 1; k < 7; k++) begin
      idx = (k - 1 > 3) ? 3 : k - 1;
      check_byte("spi_sdo", xfer_rx[k], osd_pkg::version_bytes[idx]);
    end
    // nop transaction reads back zeros
    load_cmd(osd_pkg::op_nop);
    repeat (3) xfer_tx.push_back(8'(next_rand() >> 24));
    spi_xfer();
    foreach (xfer_rx[k]) check_byte("spi_sdo", xfer_rx[k], 8'h00);
    check_config(exp_cfg);
  endtask

  task automatic memory_stream();
    build_mem_write(next_rand(), n_words);
    spi_xfer();
    wait_bus_writes(n_words);
    compare_bus_writes();
    check_flag("fifo_full", fifo_full, 1'b0);
  endtask

  // slave stalls until the fifo fills
  task automatic backpressure_fill();
    ack_hold <= 1'b1;
    @(posedge clk);
    build_mem_write(next_rand(), fifo_depth);
    spi_xfer();
    check_flag("fifo_full", fifo_full, 1'b1);
    check_flag("wb_stb", wb_stb, 1'b1);
    if (bus_q.size() != 0) begin
      other_errs++;
      $display("bus write accepted while acks were held");
    end
    ack_hold <= 1'b0;
    wait_bus_writes(fifo_depth);
    compare_bus_writes();
    check_flag("fifo_full", fifo_full, 1'b0);
    check_flag("wb_cyc", wb_cyc, 1'b0);
  endtask

  // ----------------------------------------
  // main sequence and watchdog
  // ----------------------------------------
  initial begin
    reset    = 1'b1;
    spi_cs_n = 1'b1;
    spi_sck  = 1'b0;
    spi_sdi  = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(posedge clk);
    after_reset_state();
    register_writes();
    version_readback();
    memory_stream();
    backpressure_fill();
    $display("errors: config %0d, word %0d, byte %0d, flag %0d, other %0d",
             cfg_errs, word_errs, byte_errs, flag_errs, other_errs);
    if (cfg_errs + word_errs + byte_errs + flag_errs + other_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: bench/osd_ctrl_sva.sv
// wishbone master protocol checks
module osd_ctrl_sva (
  input logic                       clk,
  input logic                       reset,
  input logic                       pop,
  input logic                       wb_cyc,
  input logic                       wb_stb,
  input logic                       wb_we,
  input logic [1:0]                 wb_sel,
  input logic [osd_pkg::addr_w-1:0] wb_adr,
  input logic [osd_pkg::data_w-1:0] wb_dat_w,
  input logic                       wb_ack
);

  // ----------------------------------------
  // classic single write rules
  // ----------------------------------------
  ap_stb_cyc_we: assert property (@(posedge clk) disable iff (reset)
    wb_stb |-> wb_cyc && wb_we)
    else $error("wb_stb high without wb_cyc and wb_we");

  // full word lanes only
  ap_sel_full: assert property (@(posedge clk) disable iff (reset)
    wb_stb |-> wb_sel == 2'b11)
    else $error("wb_sel not 11 during wb_stb");

  // request held until the slave answers
  ap_hold_req: assert property (@(posedge clk) disable iff (reset)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w))
    else $error("wb request changed before wb_ack");

  // bus released after each ack
  ap_gap: assert property (@(posedge clk) disable iff (reset)
    wb_stb && wb_ack |=> !wb_stb && !wb_cyc)
    else $error("no idle cycle after acknowledged write");

  ap_pop_ack: assert property (@(posedge clk) disable iff (reset)
    pop |-> wb_ack && wb_stb)
    else $error("fifo pop without acknowledged write");

endmodule

bind wb_write_master osd_ctrl_sva i_sva (.*);

// File: rtl/osd_ctrl_top.sv
// osd host command port
module osd_ctrl_top #(
  parameter int fifo_depth = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  // spi slave
  input  logic                       spi_cs_n,
  input  logic                       spi_sck,
  input  logic                       spi_sdi,
  output logic                       spi_sdo,
  // wishbone master
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic                       wb_we,
  output logic [1:0]                 wb_sel,
  output logic [osd_pkg::addr_w-1:0] wb_adr,
  output logic [osd_pkg::data_w-1:0] wb_dat_w,
  input  logic                       wb_ack,
  // status
  output osd_pkg::sys_config_t       sys_config,
  output logic                       fifo_full
);

  osd_pkg::spi_byte_t  spi_rx;
  logic [7:0]          rd_byte;
  osd_pkg::reg_write_t reg_wr;
  osd_pkg::mem_byte_t  mem_byte;
  osd_pkg::mem_word_t  head;
  logic                not_empty;
  logic                pop;

  // ----------------------------------------
  // spi front end
  // ----------------------------------------
  spi_byte_rx i_spi (
    .clk      (clk),
    .reset    (reset),
    .spi_cs_n (spi_cs_n),
    .spi_sck  (spi_sck),
    .spi_sdi  (spi_sdi),
    .spi_sdo  (spi_sdo),
    .rd_byte  (rd_byte),
    .rx       (spi_rx)
  );

  cmd_decoder i_dec (
    .clk      (clk),
    .reset    (reset),
    .rx       (spi_rx),
    .rd_byte  (rd_byte),
    .reg_wr   (reg_wr),
    .mem_byte (mem_byte)
  );

  // register path
  config_regs i_cfg (
    .clk        (clk),
    .reset      (reset),
    .reg_wr     (reg_wr),
    .sys_config (sys_config)
  );

  // ----------------------------------------
  // memory write path
  // ----------------------------------------
  mem_word_fifo #(
    .fifo_depth (fifo_depth)
  ) i_fifo (
    .clk       (clk),
    .reset     (reset),
    .mem_byte  (mem_byte),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .full      (fifo_full)
  );

  wb_write_master i_wb (
    .clk       (clk),
    .reset     (reset),
    .head      (head),
    .not_empty (not_empty),
    .pop       (pop),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_sel    (wb_sel),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_ack    (wb_ack)
  );

endmodule

// File: rtl/wb_write_master.sv
// wishbone classic write master
module wb_write_master (
  input  logic                       clk,
  input  logic                       reset,
  input  osd_pkg::mem_word_t         head,
  input  logic                       not_empty,
  output logic                       pop,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic                       wb_we,
  output logic [1:0]                 wb_sel,
  output logic [osd_pkg::addr_w-1:0] wb_adr,
  output logic [osd_pkg::data_w-1:0] wb_dat_w,
  input  logic                       wb_ack
);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_gap
  } state_e;

  state_e state;
  logic   active;

  // ----------------------------------------
  // single write per fifo entry
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (not_empty) state <= st_write;
        end
        // wait for the slave
        st_write: begin
          if (wb_ack) state <= st_gap;
        end
        // bus released one cycle
        st_gap: begin
          state <= not_empty ? st_write : st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign active = (state == st_write);

  // entry leaves the fifo with the ack
  assign pop = active && wb_ack;

  assign wb_cyc = active;
  assign wb_stb = active;
  assign wb_we  = active;
  assign wb_sel = active ? 2'b11 : 2'b00;

  // head is stable until pop
  assign wb_adr   = head.adr;
  assign wb_dat_w = head.dat;

endmodule

// File: rtl/mem_word_fifo.sv
// memory write word fifo
module mem_word_fifo #(
  parameter int fifo_depth = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  osd_pkg::mem_byte_t mem_byte,
  input  logic               pop,
  output osd_pkg::mem_word_t head,
  output logic               not_empty,
  output logic               full
);

  localparam int ptr_w = $clog2(fifo_depth);
  localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(fifo_depth);
  localparam logic [osd_pkg::addr_w-1:0] adr_step = 2;

  logic [osd_pkg::addr_w-1:0] run_adr;
  logic [7:0]                 hi_byte;
  logic                       have_hi;
  logic                       word_done;
  logic                       push;

  osd_pkg::mem_word_t entries [fifo_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [ptr_w:0]     count;

  // second byte of a pair completes the word
  assign word_done = mem_byte.valid && !mem_byte.addr_phase && have_hi;
  assign push      = word_done && !full;

  // ----------------------------------------
  // word assembly
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      have_hi <= 1'b0;
    end else if (mem_byte.valid) begin
      // address phase restarts the pairing
      have_hi <= mem_byte.addr_phase ? 1'b0 : !have_hi;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_byte.valid) begin
      if (mem_byte.addr_phase) begin
        // lsb first, page byte dropped
        case (mem_byte.idx)
          2'd0: run_adr[7:0]   <= mem_byte.data;
          2'd1: run_adr[15:8]  <= mem_byte.data;
          2'd2: run_adr[23:16] <= mem_byte.data;
          default: begin
          end
        endcase
      end else if (!have_hi) begin
        hi_byte <= mem_byte.data;
      end else begin
        // advances even when the word is dropped
        run_adr <= run_adr + adr_step;
      end
    end
  end

  // ----------------------------------------
  // circular buffer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= '{adr: run_adr, dat: {hi_byte, mem_byte.data}};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: begin
        end
      endcase
    end
  end

  // head entry stays put until popped
  assign head      = entries[rd_ptr];
  assign not_empty = (count != '0);
  assign full      = (count == full_count);

endmodule

// File: rtl/config_regs.sv
// configuration register bank
module config_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  osd_pkg::reg_write_t  reg_wr,
  output osd_pkg::sys_config_t sys_config
);

  // ----------------------------------------
  // register writes
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      sys_config <= osd_pkg::config_reset;
    end else if (reg_wr.valid) begin
      case (reg_wr.op)
        // halt, reset, user reset
        osd_pkg::op_reset_ctrl: begin
          {sys_config.cpu_halt, sys_config.cpu_reset, sys_config.user_reset} <=
            reg_wr.data[2:0];
        end
        // keyboard disable, osd enable
        osd_pkg::op_osd_ctrl: begin
          {sys_config.key_disable, sys_config.osd_enable} <= reg_wr.data[1:0];
        end
        // aga, ecs, a1000, ntsc, turbo
        osd_pkg::op_chip_cfg: sys_config.chipset <= reg_wr.data[4:0];
        // fast kick, cache, cpu type
        osd_pkg::op_cpu_cfg: sys_config.cpu <= reg_wr.data[3:0];
        // hrtmon, fast, slow, chip
        osd_pkg::op_mem_cfg: sys_config.memory <= reg_wr.data[6:0];
        // full byte used here
        osd_pkg::op_video_cfg: begin
          {sys_config.dither, sys_config.hires_filter,
           sys_config.lores_filter, sys_config.scanline} <= reg_wr.data;
        end
        // drive count and speed
        osd_pkg::op_floppy_cfg: sys_config.floppy <= reg_wr.data[3:0];
        // slave, master, controller enable
        osd_pkg::op_hdd_cfg: sys_config.ide <= reg_wr.data[2:0];
        // cd32 pad mode, autofire rate
        osd_pkg::op_joy_cfg: begin
          {sys_config.cd32pad, sys_config.autofire} <= reg_wr.data[2:0];
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: rtl/cmd_decoder.sv
// osd command decoder
module cmd_decoder (
  input  logic                clk,
  input  logic                reset,
  input  osd_pkg::spi_byte_t  rx,
  output logic [7:0]          rd_byte,
  output osd_pkg::reg_write_t reg_wr,
  output osd_pkg::mem_byte_t  mem_byte
);

  osd_pkg::opcode_e cmd_op;
  osd_pkg::opcode_e op_q;
  logic [2:0]       dat_cnt;
  logic             is_reg_op;
  logic             is_data;
  logic [1:0]       ver_idx;

  // ----------------------------------------
  // opcode decode
  // ----------------------------------------
  // unknown codes fall back to nop
  always_comb begin
    cmd_op = osd_pkg::op_nop;
    case (rx.data[7:2])
      osd_pkg::op_reset_ctrl,
      osd_pkg::op_osd_ctrl,
      osd_pkg::op_chip_cfg,
      osd_pkg::op_cpu_cfg,
      osd_pkg::op_mem_cfg,
      osd_pkg::op_video_cfg,
      osd_pkg::op_floppy_cfg,
      osd_pkg::op_hdd_cfg,
      osd_pkg::op_joy_cfg,
      osd_pkg::op_mem_write,
      osd_pkg::op_version: cmd_op = osd_pkg::opcode_e'(rx.data[7:2]);
      default: cmd_op = osd_pkg::op_nop;
    endcase
  end

  // register opcodes only
  assign is_reg_op = !(op_q inside {osd_pkg::op_nop, osd_pkg::op_mem_write,
                                    osd_pkg::op_version});
  assign is_data   = rx.valid && !rx.first;

  // ----------------------------------------
  // opcode latch and data byte counter
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      op_q    <= osd_pkg::op_nop;
      dat_cnt <= '0;
    end else if (rx.valid) begin
      if (rx.first) begin
        op_q    <= cmd_op;
        dat_cnt <= '0;
      end else if (dat_cnt != 3'd4) begin
        // saturate at 4
        dat_cnt <= dat_cnt + 3'd1;
      end
    end
  end

  // ----------------------------------------
  // routed outputs
  // ----------------------------------------
  always_ff @(posedge clk) begin
    reg_wr.op           <= op_q;
    reg_wr.data         <= rx.data;
    // bytes 0 to 3 carry the address
    mem_byte.addr_phase <= (dat_cnt != 3'd4);
    mem_byte.idx        <= dat_cnt[1:0];
    mem_byte.data       <= rx.data;

    if (reset) begin
      reg_wr.valid   <= 1'b0;
      mem_byte.valid <= 1'b0;
    end else begin
      // only the first data byte writes a register
      reg_wr.valid   <= is_data && is_reg_op && dat_cnt == 3'd0;
      mem_byte.valid <= is_data && op_q == osd_pkg::op_mem_write;
    end
  end

  // version readback
  // separator repeats once the counter saturates
  assign ver_idx = (dat_cnt > 3'd3) ? 2'd3 : dat_cnt[1:0];
  assign rd_byte = (op_q == osd_pkg::op_version) ? osd_pkg::version_bytes[ver_idx] : 8'h00;

endmodule

// File: rtl/spi_byte_rx.sv
// spi mode 0 byte slave
module spi_byte_rx (
  input  logic               clk,
  input  logic               reset,
  input  logic               spi_cs_n,
  input  logic               spi_sck,
  input  logic               spi_sdi,
  output logic               spi_sdo,
  input  logic [7:0]         rd_byte,
  output osd_pkg::spi_byte_t rx
);

  // pin order {cs_n, sck, sdi}
  logic [2:0] pin_meta;
  logic [2:0] pin_sync;
  logic       sck_d;
  logic       cs_n_s;
  logic       sck_s;
  logic       sdi_s;
  logic       sck_rise;
  logic       sck_fall;

  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [7:0] tx_shift;
  logic       first_pend;

  // ----------------------------------------
  // pin synchronisers
  // ----------------------------------------
  // cs_n goes through the same flops to stay aligned with sck
  always_ff @(posedge clk) begin
    if (reset) begin
      pin_meta <= 3'b100;
      pin_sync <= 3'b100;
      sck_d    <= 1'b0;
    end else begin
      pin_meta <= {spi_cs_n, spi_sck, spi_sdi};
      pin_sync <= pin_meta;
      sck_d    <= pin_sync[1];
    end
  end

  assign cs_n_s   = pin_sync[2];
  assign sck_s    = pin_sync[1];
  assign sdi_s    = pin_sync[0];
  assign sck_rise = sck_s & ~sck_d;
  assign sck_fall = ~sck_s & sck_d;

  // ----------------------------------------
  // bit framing
  // ----------------------------------------
  always_ff @(posedge clk) begin
    // sample on rising edge, msb first
    if (sck_rise) begin
      rx_shift <= {rx_shift[5:0], sdi_s};
    end
    if (sck_rise && bit_cnt == 3'd7) begin
      rx.data  <= {rx_shift, sdi_s};
      rx.first <= first_pend;
    end

    if (reset) begin
      bit_cnt    <= '0;
      first_pend <= 1'b1;
      tx_shift   <= '0;
      rx.valid   <= 1'b0;
    end else begin
      rx.valid <= 1'b0;
      if (cs_n_s) begin
        // idle, next byte is a command
        bit_cnt    <= '0;
        first_pend <= 1'b1;
        tx_shift   <= '0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            rx.valid   <= 1'b1;
            first_pend <= 1'b0;
          end
        end
        // falling edge after bit 8 loads the next read byte
        if (sck_fall) begin
          if (bit_cnt == 3'd0)
            tx_shift <= rd_byte;
          else
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
    end
  end

  // quiet line outside a transaction
  assign spi_sdo = tx_shift[7] & ~spi_cs_n;

endmodule

// File: rtl/osd_pkg.sv
// osd command port shared types
package osd_pkg;

  // wishbone bus widths
  localparam int data_w = 16;
  localparam int addr_w = 24;

  // ----------------------------------------
  // command opcodes
  // ----------------------------------------
  // upper six bits of the spi command byte
  typedef enum logic [5:0] {
    op_nop        = 6'b0_000_00,
    op_reset_ctrl = 6'b0_000_10,
    op_osd_ctrl   = 6'b0_010_10,
    op_chip_cfg   = 6'b0_000_01,
    op_cpu_cfg    = 6'b0_001_01,
    op_mem_cfg    = 6'b0_010_01,
    op_video_cfg  = 6'b0_011_01,
    op_floppy_cfg = 6'b0_100_01,
    op_hdd_cfg    = 6'b0_101_01,
    op_joy_cfg    = 6'b0_110_01,
    op_mem_write  = 6'b0_001_11,
    op_version    = 6'b1_000_10
  } opcode_e;

  // ----------------------------------------
  // stage payloads
  // ----------------------------------------
  // byte from the spi slave
  typedef struct packed {
    logic       valid;
    logic       first;
    logic [7:0] data;
  } spi_byte_t;

  typedef struct packed {
    logic       valid;
    opcode_e    op;
    logic [7:0] data;
  } reg_write_t;

  // memory stream byte, idx is the address byte number
  typedef struct packed {
    logic       valid;
    logic       addr_phase;
    logic [1:0] idx;
    logic [7:0] data;
  } mem_byte_t;

  typedef struct packed {
    logic [addr_w-1:0] adr;
    logic [data_w-1:0] dat;
  } mem_word_t;

  // ----------------------------------------
  // configuration outputs
  // ----------------------------------------
  typedef struct packed {
    logic       cpu_halt;
    logic       cpu_reset;
    logic       user_reset;
    logic       key_disable;
    logic       osd_enable;
    logic [4:0] chipset;
    logic [3:0] cpu;
    logic [6:0] memory;
    logic [1:0] dither;
    logic [1:0] hires_filter;
    logic [1:0] lores_filter;
    logic [1:0] scanline;
    logic [3:0] floppy;
    logic [2:0] ide;
    logic       cd32pad;
    logic [1:0] autofire;
  } sys_config_t;

  // cpu held in halt and reset until the host lets it go
  localparam sys_config_t config_reset = '{
    cpu_halt:  1'b1,
    cpu_reset: 1'b1,
    memory:    7'b0000101,
    default:   '0
  };

  // beta flag, major, minor, separator
  localparam logic [0:3][7:0] version_bytes = {8'h01, 8'h02, 8'h05, 8'hff};

endpackage
